// File: bench/audio_tb_tasks.svh
    task automatic check_sample(input string name, input audio_pkg::sample_t exp,
            input audio_pkg::sample_t act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input audio_pkg::wb_data_t exp,
            input audio_pkg::wb_data_t act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // ack is due exactly one clock after the request
    task automatic bus_transfer(input logic we, input audio_pkg::reg_addr_t adr,
            input audio_pkg::wb_data_t dat);
        @(posedge clk_100_output);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = dat;
        @(posedge clk_100_output);
        #1;
        if (wb_ack !== 1'b1) begin
            errors = errors + 1;
            $display("no ack one clock after the request to address %0d at %0t", adr, $time);
        end else if (!we) begin
            check_data("wb_dat_r", m_rd, wb_dat_r);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input audio_pkg::reg_addr_t adr, input audio_pkg::wb_data_t dat);
        bus_transfer(1'b1, adr, dat);
    endtask

    task automatic bus_read(input audio_pkg::reg_addr_t adr);
        bus_transfer(1'b0, adr, '0);
    endtask

    task automatic wait_samples(input int count);
        repeat (count) begin
            @(negedge clk_100_output);
            while (!sample_valid) begin
                @(negedge clk_100_output);
            end
        end
    endtask

    // until the model fifo is empty and back in idle
    task automatic drain_fifo();
        while (m_push || !m_idle || (m_q.size() != 0)) begin
            @(negedge clk_100_output);
        end
    endtask

// File: bench/audio_tb.sv
`timescale 1ns/1ps

module audio_tb;

    localparam int CLK_PERIOD = 20;
    localparam int N_PHASES = 6;
    localparam int PHASE_CYCLES = 6000;
    localparam int MARGIN_CYCLES = 2000;
    // writable bits of the first five register words
    localparam audio_pkg::wb_data_t WR_MASK [5] =
        '{16'hffff, 16'h007f, 16'h00ff, 16'hffff, 16'h001f};
    // high steps out of 8 for duty 0..3
    localparam int HIGH_STEPS [4] = '{1, 2, 4, 6};

    logic clk_100_output;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    audio_pkg::reg_addr_t wb_adr;
    audio_pkg::wb_data_t wb_dat_w;
    audio_pkg::wb_data_t wb_dat_r;
    logic wb_ack;
    audio_pkg::sample_t sample_l;
    audio_pkg::sample_t sample_r;
    logic sample_valid;
    logic fifo_req;

    int errors = 0;
    int seed;
    int gap = 0;
    logic gap_armed = 1'b0;

    // reference model starts from the reset state
    audio_pkg::wb_data_t m_reg [5] = '{default: '0};
    audio_pkg::wb_data_t m_rd = '0;
    logic m_seen = 1'b0;
    logic m_restart = 1'b0;
    logic m_push = 1'b0;
    audio_pkg::wb_data_t m_sq_cnt = '0;
    logic [2:0] m_step = '0;
    audio_pkg::sample_t m_sq = '0;
    audio_pkg::ds_byte_t m_q [$];
    audio_pkg::ds_byte_t m_held = '0;
    logic m_idle = 1'b1;
    audio_pkg::wb_data_t m_rate_cnt = '0;
    logic m_ovf = 1'b0;
    logic m_req = 1'b0;
    logic [5:0] m_mix_cnt = '0;
    logic m_valid = 1'b0;
    audio_pkg::sample_t m_l = '0;
    audio_pkg::sample_t m_r = '0;

    `include "audio_tb_tasks.svh"

    audio_top dut_i (
        .clk_100_output(clk_100_output), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sample_l(sample_l), .sample_r(sample_r), .sample_valid(sample_valid),
        .fifo_req(fifo_req)
    );

    initial begin
        clk_100_output = 1'b0;
        forever #(CLK_PERIOD / 2) clk_100_output = ~clk_100_output;
    end

    initial begin
        #((N_PHASES * PHASE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    // next word from the seeded generator
    function automatic audio_pkg::wb_data_t rand_word();
        return audio_pkg::wb_data_t'($random(seed));
    endfunction

    // one side of the mix clamped to 16 bits
    function automatic audio_pkg::sample_t mix_side(input logic sq_on, input logic ds_on);
        int sum;
        sum = 0;
        if (sq_on) begin
            sum = sum + m_sq;
        end
        if (ds_on) begin
            sum = sum + int'(m_held) * (m_reg[4][4] ? 128 : 256);
        end
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return audio_pkg::sample_t'(sum);
    endfunction

    always @(posedge clk_100_output) begin
        logic take;
        logic full;
        logic was_empty;
        logic rate_hit;
        int amp;
        if (!rst) begin
            take = wb_cyc && wb_stb && !m_seen;
            m_seen = wb_cyc && wb_stb;
            if (take && !wb_we) begin
                m_rd = (wb_adr < 3'd5) ? m_reg[wb_adr] : '0;
                if (wb_adr == audio_pkg::REG_STATUS) begin
                    m_rd = {10'd0, m_ovf, audio_pkg::fifo_level_t'(m_q.size())};
                end
            end
            // mixer sees channel outputs from before this edge
            m_valid = (m_mix_cnt == 6'd63);
            if (m_valid) begin
                m_l = mix_side(m_reg[4][0], m_reg[4][2]);
                m_r = mix_side(m_reg[4][1], m_reg[4][3]);
            end
            m_mix_cnt = m_mix_cnt + 1'b1;
            if (m_restart) begin
                m_step = '0;
                m_sq_cnt = '0;
            end else if (m_sq_cnt == m_reg[0]) begin
                m_step = m_step + 1'b1;
                m_sq_cnt = '0;
            end else begin
                m_sq_cnt = m_sq_cnt + 1'b1;
            end
            amp = int'(m_reg[1][5:2]) * 16;
            if (!m_reg[1][6]) begin
                m_sq = '0;
            end else begin
                m_sq = audio_pkg::sample_t'((m_step < HIGH_STEPS[m_reg[1][1:0]]) ? amp : -amp);
            end
            full = (m_q.size() == audio_pkg::FIFO_DEPTH);
            was_empty = (m_q.size() == 0);
            rate_hit = (m_rate_cnt == m_reg[3]);
            if (!was_empty && (m_idle || rate_hit)) begin
                m_held = m_q.pop_front();
            end
            if (m_push && !full) begin
                m_q.push_back(m_reg[2][7:0]);
            end
            if (m_push && full) begin
                m_ovf = 1'b1;
            end else if (take && !wb_we && (wb_adr == audio_pkg::REG_STATUS)) begin
                m_ovf = 1'b0;
            end
            if (m_idle) begin
                m_rate_cnt = '0;
                m_idle = was_empty;
            end else if (rate_hit) begin
                m_rate_cnt = '0;
                if (was_empty) begin
                    m_idle = 1'b1;
                    m_held = '0;
                end
            end else begin
                m_rate_cnt = m_rate_cnt + 1'b1;
            end
            m_req = (m_q.size() <= audio_pkg::FIFO_REQ_LEVEL);
            // register writes land last so the pulses act on the next edge
            m_restart = take && wb_we && (wb_adr <= audio_pkg::REG_SQ_CTRL);
            m_push = take && wb_we && (wb_adr == audio_pkg::REG_DS_DATA);
            if (take && wb_we && (wb_adr < 3'd5)) begin
                m_reg[wb_adr] = wb_dat_w & WR_MASK[wb_adr];
            end
        end
    end

    always @(negedge clk_100_output) begin
        if (!rst) begin
            check_flag("sample_valid", m_valid, sample_valid);
            check_flag("fifo_req", m_req, fifo_req);
            gap = gap + 1;
            if (sample_valid) begin
                check_sample("sample_l", m_l, sample_l);
                check_sample("sample_r", m_r, sample_r);
                if (gap_armed) begin
                    check_data("sample_valid period", 16'd64, audio_pkg::wb_data_t'(gap));
                end
                gap = 0;
                gap_armed = 1'b1;
            end
        end
    end

    initial begin
        audio_pkg::reg_addr_t adr;
        audio_pkg::wb_data_t dat;
        seed = 32'h2f80_3242;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (5) @(posedge clk_100_output);
        #1;
        rst = 1'b0;

        // direct routed before any push gives silence
        bus_write(audio_pkg::REG_MIX_CTRL, 16'h000c);
        wait_samples(2);

        repeat (24) begin
            adr = audio_pkg::reg_addr_t'($random(seed));
            dat = rand_word();
            if (adr == audio_pkg::REG_DS_RATE) begin
                dat = dat & 16'h001f;
            end
            bus_write(adr, dat);
            drain_fifo();
            bus_read(adr);
        end

        // square tone on both sides
        bus_write(audio_pkg::REG_MIX_CTRL, 16'h0003);
        repeat (3) begin
            bus_write(audio_pkg::REG_SQ_PERIOD, rand_word() & 16'h001f);
            bus_write(audio_pkg::REG_SQ_CTRL, 16'h0040 | (rand_word() & 16'h003f));
            wait_samples(15);
        end

        // direct playback at full or half volume
        repeat (2) begin
            bus_write(audio_pkg::REG_MIX_CTRL, 16'h000c | (rand_word() & 16'h0010));
            bus_write(audio_pkg::REG_DS_RATE, 16'd16 + (rand_word() & 16'h003f));
            repeat (10) begin
                bus_write(audio_pkg::REG_DS_DATA, rand_word());
            end
            drain_fifo();
            wait_samples(2);
        end

        // slow pops so the fifo fills and overflows
        bus_write(audio_pkg::REG_DS_RATE, 16'd300);
        repeat (19) begin
            bus_write(audio_pkg::REG_DS_DATA, rand_word());
            bus_read(audio_pkg::REG_STATUS);
        end
        drain_fifo();
        bus_read(audio_pkg::REG_STATUS);

        // extreme bytes against a full volume square
        bus_write(audio_pkg::REG_DS_RATE, 16'd250);
        bus_write(audio_pkg::REG_SQ_PERIOD, rand_word() & 16'h000f);
        bus_write(audio_pkg::REG_SQ_CTRL, 16'h007c | (rand_word() & 16'h0003));
        repeat (8) begin
            // left always mixes both channels at full scale
            bus_write(audio_pkg::REG_MIX_CTRL, 16'h0005 | (rand_word() & 16'h000a));
            bus_write(audio_pkg::REG_DS_DATA,
                ((rand_word() & 16'h0001) != 16'h0000) ? 16'h007f : 16'h0080);
            wait_samples(3);
            drain_fifo();
        end

        wait_samples(10);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: common/audio_pkg.sv
package audio_pkg;

    typedef logic [15:0] wb_data_t;
    typedef logic [2:0] reg_addr_t;
    typedef logic signed [15:0] sample_t;
    typedef logic signed [7:0] ds_byte_t;
    typedef logic [1:0] duty_t;
    typedef logic [3:0] volume_t;
    // occupancy 0..16 needs one bit more than the pointers
    typedef logic [4:0] fifo_level_t;

    // register word addresses
    localparam reg_addr_t REG_SQ_PERIOD = 3'd0;
    localparam reg_addr_t REG_SQ_CTRL = 3'd1;
    localparam reg_addr_t REG_DS_DATA = 3'd2;
    localparam reg_addr_t REG_DS_RATE = 3'd3;
    localparam reg_addr_t REG_MIX_CTRL = 3'd4;
    localparam reg_addr_t REG_STATUS = 3'd5;

    // SQ_CTRL holds duty in [1:0], volume in [5:2] and enable in [6]
    // MIX_CTRL routes square left [0], square right [1], direct left [2]
    //   and direct right [3], and halves the direct volume with [4]
    // STATUS reports the fifo level in [4:0] and overflow in [5]
    localparam int MIX_CTRL_W = 5;
    localparam int MIX_SQ_L = 0;
    localparam int MIX_SQ_R = 1;
    localparam int MIX_DS_L = 2;
    localparam int MIX_DS_R = 3;
    localparam int MIX_DS_HALF = 4;

    // direct sound fifo
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_REQ_LEVEL = 8;

    // output sample cadence
    localparam int SAMPLE_DIV = 64;
    localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);

    // square is volume * 16 and direct is byte * 256
    localparam int SQ_SCALE_SHIFT = 4;
    localparam int DS_SCALE_SHIFT = 8;

    // mixer clamp limits
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

endpackage

// File: direct_sound/direct_fifo.sv
`timescale 1ns/1ps

module direct_fifo (
    input logic clk_100_output,
    input logic rst,
    input logic ds_push,
    input audio_pkg::ds_byte_t ds_push_data,
    input audio_pkg::wb_data_t ds_rate,
    input logic ovf_clear,
    output audio_pkg::sample_t ds_sample,
    output audio_pkg::fifo_level_t fifo_level,
    output logic overflow,
    output logic fifo_req
);

    typedef enum logic {DS_IDLE, DS_PLAY} ds_state_t;

    ds_state_t state;
    audio_pkg::ds_byte_t fifo_mem [audio_pkg::FIFO_DEPTH];
    logic [audio_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [audio_pkg::FIFO_PTR_W-1:0] rd_ptr;
    audio_pkg::fifo_level_t level_next;
    audio_pkg::wb_data_t rate_cnt;
    audio_pkg::ds_byte_t held;
    logic full;
    logic empty;
    logic push_ok;
    logic pop;
    logic rate_hit;

    assign full = (fifo_level == audio_pkg::FIFO_DEPTH);
    assign empty = (fifo_level == '0);
    // a full fifo drops the push even if a pop happens
    assign push_ok = ds_push && !full;
    assign rate_hit = (rate_cnt == ds_rate);
    // idle pops at once and play pops once per rate interval
    assign pop = !empty && ((state == DS_IDLE) || rate_hit);
    assign ds_sample = audio_pkg::sample_t'(held);

    always_comb begin
        level_next = fifo_level;
        if (push_ok && !pop) begin
            level_next = fifo_level + 1'b1;
        end else if (pop && !push_ok) begin
            level_next = fifo_level - 1'b1;
        end
    end

    always_ff @(posedge clk_100_output) begin
        if (push_ok) begin
            fifo_mem[wr_ptr] <= ds_push_data;
        end
    end

    always_ff @(posedge clk_100_output) begin
        if (rst) begin
            state <= DS_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_level <= '0;
            rate_cnt <= '0;
            held <= '0;
            overflow <= 1'b0;
            fifo_req <= 1'b0;
        end else begin
            fifo_level <= level_next;
            fifo_req <= (level_next <= audio_pkg::FIFO_REQ_LEVEL);
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                held <= fifo_mem[rd_ptr];
            end
            // a new overflow beats a clear in the same clock
            if (ds_push && full) begin
                overflow <= 1'b1;
            end else if (ovf_clear) begin
                overflow <= 1'b0;
            end
            case (state)
                DS_IDLE: begin
                    rate_cnt <= '0;
                    if (!empty) begin
                        state <= DS_PLAY;
                    end
                end
                DS_PLAY: begin
                    if (rate_hit) begin
                        rate_cnt <= '0;
                        if (empty) begin
                            state <= DS_IDLE;
                            held <= '0;
                        end
                    end else begin
                        rate_cnt <= rate_cnt + 1'b1;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    a_level_max: assert property (@(posedge clk_100_output) disable iff (rst)
        fifo_level <= audio_pkg::FIFO_DEPTH);

endmodule

// File: square/square_channel.sv
`timescale 1ns/1ps

module square_channel (
    input logic clk_100_output,
    input logic rst,
    input audio_pkg::wb_data_t sq_period,
    input audio_pkg::duty_t sq_duty,
    input audio_pkg::volume_t sq_volume,
    input logic sq_enable,
    input logic sq_restart,
    output audio_pkg::sample_t sq_sample
);

    audio_pkg::wb_data_t period_cnt;
    logic [2:0] step;
    logic [2:0] step_next;
    logic [2:0] high_steps;
    logic period_done;
    logic step_high;
    audio_pkg::sample_t amplitude;

    assign period_done = (period_cnt == sq_period);

    // output follows step_next so step 0 shows right after a restart
    always_comb begin
        if (sq_restart) begin
            step_next = '0;
        end else if (period_done) begin
            step_next = step + 1'b1;
        end else begin
            step_next = step;
        end
    end

    // high steps out of 8 per duty select
    always_comb begin
        case (sq_duty)
            2'd0: high_steps = 3'd1;
            2'd1: high_steps = 3'd2;
            2'd2: high_steps = 3'd4;
            default: high_steps = 3'd6;
        endcase
    end

    assign step_high = (step_next < high_steps);
    assign amplitude = audio_pkg::sample_t'(sq_volume) << audio_pkg::SQ_SCALE_SHIFT;

    always_ff @(posedge clk_100_output) begin
        if (rst) begin
            period_cnt <= '0;
            step <= '0;
            sq_sample <= '0;
        end else begin
            step <= step_next;
            if (sq_restart || period_done) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
            if (!sq_enable) begin
                sq_sample <= '0;
            end else if (step_high) begin
                sq_sample <= amplitude;
            end else begin
                sq_sample <= -amplitude;
            end
        end
    end

    // full volume is 15 * 16
    a_sq_range: assert property (@(posedge clk_100_output) disable iff (rst)
        (sq_sample <= 16'sd240) && (sq_sample >= -16'sd240));

endmodule

// File: verilog/audio_top.sv
`timescale 1ns/1ps

module audio_top (
    input logic clk_100_output,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input audio_pkg::reg_addr_t wb_adr,
    input audio_pkg::wb_data_t wb_dat_w,
    output audio_pkg::wb_data_t wb_dat_r,
    output logic wb_ack,
    output audio_pkg::sample_t sample_l,
    output audio_pkg::sample_t sample_r,
    output logic sample_valid,
    output logic fifo_req
);

    // square settings
    audio_pkg::wb_data_t sq_period;
    audio_pkg::duty_t sq_duty;
    audio_pkg::volume_t sq_volume;
    logic sq_enable;
    logic sq_restart;
    audio_pkg::sample_t sq_sample;

    // direct sound
    logic ds_push;
    audio_pkg::ds_byte_t ds_push_data;
    audio_pkg::wb_data_t ds_rate;
    logic ovf_clear;
    audio_pkg::fifo_level_t fifo_level;
    logic overflow;
    audio_pkg::sample_t ds_sample;

    logic [audio_pkg::MIX_CTRL_W-1:0] mix_ctrl;

    sound_regs regs_i (
        .clk_100_output(clk_100_output), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .sq_period(sq_period), .sq_duty(sq_duty), .sq_volume(sq_volume),
        .sq_enable(sq_enable), .sq_restart(sq_restart),
        .ds_push(ds_push), .ds_push_data(ds_push_data), .ds_rate(ds_rate),
        .mix_ctrl(mix_ctrl), .ovf_clear(ovf_clear),
        .fifo_level(fifo_level), .overflow(overflow)
    );

    square_channel square_i (
        .clk_100_output(clk_100_output), .rst(rst),
        .sq_period(sq_period), .sq_duty(sq_duty), .sq_volume(sq_volume),
        .sq_enable(sq_enable), .sq_restart(sq_restart), .sq_sample(sq_sample)
    );

    direct_fifo direct_i (
        .clk_100_output(clk_100_output), .rst(rst),
        .ds_push(ds_push), .ds_push_data(ds_push_data), .ds_rate(ds_rate),
        .ovf_clear(ovf_clear), .ds_sample(ds_sample), .fifo_level(fifo_level),
        .overflow(overflow), .fifo_req(fifo_req)
    );

    sound_mixer mixer_i (
        .clk_100_output(clk_100_output), .rst(rst),
        .sq_sample(sq_sample), .ds_sample(ds_sample), .mix_ctrl(mix_ctrl),
        .sample_l(sample_l), .sample_r(sample_r), .sample_valid(sample_valid)
    );

endmodule

// File: verilog/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer (
    input logic clk_100_output,
    input logic rst,
    input audio_pkg::sample_t sq_sample,
    input audio_pkg::sample_t ds_sample,
    input logic [audio_pkg::MIX_CTRL_W-1:0] mix_ctrl,
    output audio_pkg::sample_t sample_l,
    output audio_pkg::sample_t sample_r,
    output logic sample_valid
);

    logic [audio_pkg::SAMPLE_CNT_W-1:0] sample_cnt;
    logic last_cnt;
    audio_pkg::sample_t ds_scaled;
    audio_pkg::sample_t sq_l;
    audio_pkg::sample_t sq_r;
    audio_pkg::sample_t ds_l;
    audio_pkg::sample_t ds_r;
    logic signed [16:0] sum_l;
    logic signed [16:0] sum_r;

    // clamp a 17 bit sum to the 16 bit range
    function automatic audio_pkg::sample_t saturate(input logic signed [16:0] sum);
        if (sum > audio_pkg::SAMPLE_MAX) begin
            return audio_pkg::sample_t'(audio_pkg::SAMPLE_MAX);
        end else if (sum < audio_pkg::SAMPLE_MIN) begin
            return audio_pkg::sample_t'(audio_pkg::SAMPLE_MIN);
        end
        return audio_pkg::sample_t'(sum);
    endfunction

    assign last_cnt = (sample_cnt == audio_pkg::SAMPLE_CNT_W'(audio_pkg::SAMPLE_DIV - 1));

    always_comb begin
        if (mix_ctrl[audio_pkg::MIX_DS_HALF]) begin
            ds_scaled = ds_sample <<< (audio_pkg::DS_SCALE_SHIFT - 1);
        end else begin
            ds_scaled = ds_sample <<< audio_pkg::DS_SCALE_SHIFT;
        end
        sq_l = mix_ctrl[audio_pkg::MIX_SQ_L] ? sq_sample : '0;
        sq_r = mix_ctrl[audio_pkg::MIX_SQ_R] ? sq_sample : '0;
        ds_l = mix_ctrl[audio_pkg::MIX_DS_L] ? ds_scaled : '0;
        ds_r = mix_ctrl[audio_pkg::MIX_DS_R] ? ds_scaled : '0;
        // one bit of headroom before the clamp
        sum_l = 17'(sq_l) + 17'(ds_l);
        sum_r = 17'(sq_r) + 17'(ds_r);
    end

    always_ff @(posedge clk_100_output) begin
        if (rst) begin
            sample_cnt <= '0;
            sample_valid <= 1'b0;
            sample_l <= '0;
            sample_r <= '0;
        end else begin
            sample_valid <= last_cnt;
            if (last_cnt) begin
                sample_cnt <= '0;
                sample_l <= saturate(sum_l);
                sample_r <= saturate(sum_r);
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/sound_regs.sv
`timescale 1ns/1ps

module sound_regs (
    input logic clk_100_output,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input audio_pkg::reg_addr_t wb_adr,
    input audio_pkg::wb_data_t wb_dat_w,
    output audio_pkg::wb_data_t wb_dat_r,
    output logic wb_ack,
    output audio_pkg::wb_data_t sq_period,
    output audio_pkg::duty_t sq_duty,
    output audio_pkg::volume_t sq_volume,
    output logic sq_enable,
    output logic sq_restart,
    output logic ds_push,
    output audio_pkg::ds_byte_t ds_push_data,
    output audio_pkg::wb_data_t ds_rate,
    output logic [audio_pkg::MIX_CTRL_W-1:0] mix_ctrl,
    output logic ovf_clear,
    input audio_pkg::fifo_level_t fifo_level,
    input logic overflow
);

    logic req;
    logic take;
    logic done;
    audio_pkg::wb_data_t rd_data;

    assign req = wb_cyc && wb_stb;
    // done blocks a held request until stb has dropped
    assign take = req && !done;

    // status read clears overflow on the ack edge
    assign ovf_clear = take && !wb_we && (wb_adr == audio_pkg::REG_STATUS);

    always_comb begin
        case (wb_adr)
            audio_pkg::REG_SQ_PERIOD: rd_data = sq_period;
            audio_pkg::REG_SQ_CTRL: rd_data = audio_pkg::wb_data_t'({sq_enable, sq_volume, sq_duty});
            audio_pkg::REG_DS_DATA: rd_data = {8'h00, ds_push_data};
            audio_pkg::REG_DS_RATE: rd_data = ds_rate;
            audio_pkg::REG_MIX_CTRL: rd_data = audio_pkg::wb_data_t'(mix_ctrl);
            audio_pkg::REG_STATUS: rd_data = audio_pkg::wb_data_t'({overflow, fifo_level});
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_100_output) begin
        if (rst) begin
            wb_ack <= 1'b0;
            wb_dat_r <= '0;
            done <= 1'b0;
            sq_period <= '0;
            sq_duty <= '0;
            sq_volume <= '0;
            sq_enable <= 1'b0;
            sq_restart <= 1'b0;
            ds_push <= 1'b0;
            ds_push_data <= '0;
            ds_rate <= '0;
            mix_ctrl <= '0;
        end else begin
            wb_ack <= take;
            wb_dat_r <= take ? rd_data : '0;
            done <= req && (done || take);
            ds_push <= take && wb_we && (wb_adr == audio_pkg::REG_DS_DATA);
            // any square write restarts the tone
            sq_restart <= take && wb_we && ((wb_adr == audio_pkg::REG_SQ_PERIOD) ||
                (wb_adr == audio_pkg::REG_SQ_CTRL));
            if (take && wb_we) begin
                case (wb_adr)
                    audio_pkg::REG_SQ_PERIOD: sq_period <= wb_dat_w;
                    audio_pkg::REG_SQ_CTRL: begin
                        sq_duty <= wb_dat_w[1:0];
                        sq_volume <= wb_dat_w[5:2];
                        sq_enable <= wb_dat_w[6];
                    end
                    audio_pkg::REG_DS_DATA: ds_push_data <= wb_dat_w[7:0];
                    audio_pkg::REG_DS_RATE: ds_rate <= wb_dat_w;
                    audio_pkg::REG_MIX_CTRL: mix_ctrl <= wb_dat_w[audio_pkg::MIX_CTRL_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // one-clock ack per transfer
    a_ack_single: assert property (@(posedge clk_100_output) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

// File: vlog.f
+incdir+bench
common/audio_pkg.sv
verilog/sound_regs.sv
square/square_channel.sv
direct_sound/direct_fifo.sv
verilog/sound_mixer.sv
verilog/audio_top.sv
bench/audio_tb.sv
